// File: src/v850_pkg.sv
package v850_pkg;

    // Datapath and register file sizes
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    localparam int IMM5_W  = 5;
    localparam int IMM16_W = 16;  // Upper halfword of a 32-bit format

    // Instruction field positions
    localparam int OPC_LSB   = 5;
    localparam int OPC_MSB   = 10;
    localparam int OPC_W     = OPC_MSB - OPC_LSB + 1;
    localparam int REG1_LSB  = 0;   // Also imm5
    localparam int REG2_LSB  = 11;  // Bits 15:11
    localparam int REG3_LSB  = 27;  // Bits 31:27, extended format only
    localparam int SUBOP_LSB = 21;  // Bits 26:21
    localparam int SUBOP_W   = 6;
    localparam int COND_LSB  = 17;  // cccc at bits 20:17
    localparam int COND_W    = 4;
    localparam int EXT_ZERO_BIT = 16;  // Must be 0 for ADF and SBF

    // Primary opcodes
    localparam logic [OPC_W-1:0] OPC_ADD_R  = 6'b001110;
    localparam logic [OPC_W-1:0] OPC_ADD_I5 = 6'b010010;
    localparam logic [OPC_W-1:0] OPC_ADDI   = 6'b110000;
    localparam logic [OPC_W-1:0] OPC_SUB_R  = 6'b001101;
    localparam logic [OPC_W-1:0] OPC_CMP_R  = 6'b001111;
    localparam logic [OPC_W-1:0] OPC_CMP_I5 = 6'b010011;
    localparam logic [OPC_W-1:0] OPC_EXT    = 6'b111111;  // Format XI and friends

    // Extended sub-opcodes
    localparam logic [SUBOP_W-1:0] SUB_ADF = 6'b011101;
    localparam logic [SUBOP_W-1:0] SUB_SBF = 6'b011100;

    // Condition codes
    localparam logic [COND_W-1:0] COND_V  = 4'b0000;
    localparam logic [COND_W-1:0] COND_NV = 4'b1000;
    localparam logic [COND_W-1:0] COND_C  = 4'b0001;  // Same code as L
    localparam logic [COND_W-1:0] COND_NC = 4'b1001;  // Same code as NL
    localparam logic [COND_W-1:0] COND_Z  = 4'b0010;
    localparam logic [COND_W-1:0] COND_NZ = 4'b1010;
    localparam logic [COND_W-1:0] COND_NH = 4'b0011;
    localparam logic [COND_W-1:0] COND_H  = 4'b1011;
    localparam logic [COND_W-1:0] COND_N  = 4'b0100;
    localparam logic [COND_W-1:0] COND_P  = 4'b1100;
    localparam logic [COND_W-1:0] COND_T  = 4'b0101;
    localparam logic [COND_W-1:0] COND_SA = 4'b1101;  // Not allowed on ADF and SBF
    localparam logic [COND_W-1:0] COND_LT = 4'b0110;
    localparam logic [COND_W-1:0] COND_GE = 4'b1110;
    localparam logic [COND_W-1:0] COND_LE = 4'b0111;
    localparam logic [COND_W-1:0] COND_GT = 4'b1111;

    // PSW flag positions
    localparam int PSW_Z  = 0;
    localparam int PSW_S  = 1;
    localparam int PSW_OV = 2;
    localparam int PSW_CY = 3;

    // Decoded operation
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_ADD,
        OP_SUB,
        OP_CMP,
        OP_ADF,
        OP_SBF
    } op_kind_t;

endpackage

// File: src/gpr_file.sv
module gpr_file
    import v850_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic [REG_AW-1:0] raddr1_i,
    input  logic [REG_AW-1:0] raddr2_i,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]   rdata1_o,
    output logic [XLEN-1:0]   rdata2_o
);

    logic [XLEN-1:0] regs [NUM_REGS];  // r0 entry never written

    // Write port
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // Drop writes to r0
            regs[waddr_i] <= wdata_i;
        end
    end

    // Async reads, old data on a same-cycle write
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // Writeback side must present a clean address
    a_waddr_known: assert property (
        @(posedge clk) disable iff (reset_i)
        we_i |-> !$isunknown(waddr_i)
    ) else $error("gpr_file write with unknown address %b", waddr_i);

endmodule

// File: src/insn_classifier.sv
module insn_classifier
    import v850_pkg::*;
(
    input  logic [XLEN-1:0]    insn_i,
    output op_kind_t           op_o,
    output logic [REG_AW-1:0]  reg1_o,
    output logic [REG_AW-1:0]  reg2_o,
    output logic [REG_AW-1:0]  reg3_o,
    output logic [IMM5_W-1:0]  imm5_o,
    output logic [IMM16_W-1:0] imm16_o,
    output logic [COND_W-1:0]  cond_o,
    output logic               src1_imm5_o,
    output logic               src2_imm16_o
);

    logic [OPC_W-1:0]   opc;
    logic [SUBOP_W-1:0] subop;
    logic               ext_ok;  // Extended word well formed for ADF/SBF

    // Raw field slices
    assign opc   = insn_i[OPC_MSB:OPC_LSB];
    assign subop = insn_i[SUBOP_LSB +: SUBOP_W];

    assign reg1_o  = insn_i[REG1_LSB +: REG_AW];
    assign reg2_o  = insn_i[REG2_LSB +: REG_AW];
    assign reg3_o  = insn_i[REG3_LSB +: REG_AW];
    assign imm5_o  = insn_i[REG1_LSB +: IMM5_W];    // Shares the reg1 slot
    assign imm16_o = insn_i[XLEN-1 -: IMM16_W];     // Second halfword
    assign cond_o  = insn_i[COND_LSB +: COND_W];

    // Bit 16 clear and cccc not the reserved SA code
    assign ext_ok = !insn_i[EXT_ZERO_BIT] && (cond_o != COND_SA);

    always_comb begin
        op_o         = OP_NONE;  // Anything unmatched stays here
        src1_imm5_o  = 1'b0;
        src2_imm16_o = 1'b0;
        case (opc)
            OPC_ADD_R:  op_o = OP_ADD;
            OPC_SUB_R:  op_o = OP_SUB;
            OPC_CMP_R:  op_o = OP_CMP;
            OPC_ADD_I5: begin
                op_o        = OP_ADD;
                src1_imm5_o = 1'b1;
            end
            OPC_CMP_I5: begin
                op_o        = OP_CMP;
                src1_imm5_o = 1'b1;
            end
            OPC_ADDI: begin
                op_o         = OP_ADD;  // Same ALU op, imm16 in slot 2
                src2_imm16_o = 1'b1;
            end
            OPC_EXT: begin
                // Only the two carry-conditional forms are kept
                if (ext_ok && (subop == SUB_ADF)) begin
                    op_o = OP_ADF;
                end else if (ext_ok && (subop == SUB_SBF)) begin
                    op_o = OP_SBF;
                end
            end
            default: op_o = OP_NONE;
        endcase
    end

endmodule

// File: src/operand_select.sv
module operand_select
    import v850_pkg::*;
(
    input  logic [XLEN-1:0]    rdata1_i,
    input  logic [XLEN-1:0]    rdata2_i,
    input  logic [IMM5_W-1:0]  imm5_i,
    input  logic [IMM16_W-1:0] imm16_i,
    input  logic               src1_imm5_i,
    input  logic               src2_imm16_i,
    output logic [XLEN-1:0]    operand1_o,
    output logic [XLEN-1:0]    operand2_o
);

    logic [XLEN-1:0] imm5_sx;
    logic [XLEN-1:0] imm16_sx;

    // Sign extension to full width
    assign imm5_sx  = {{(XLEN-IMM5_W){imm5_i[IMM5_W-1]}}, imm5_i};
    assign imm16_sx = {{(XLEN-IMM16_W){imm16_i[IMM16_W-1]}}, imm16_i};

    // Slot 1 takes imm5 for the short immediate forms
    assign operand1_o = src1_imm5_i ? imm5_sx : rdata1_i;

    // Slot 2 takes imm16 for ADDI only
    assign operand2_o = src2_imm16_i ? imm16_sx : rdata2_i;

endmodule

// File: src/cond_eval.sv
module cond_eval
    import v850_pkg::*;
(
    input  logic [COND_W-1:0] cond_i,
    input  logic [XLEN-1:0]   psw_i,
    output logic              cond_true_o
);

    logic z;
    logic s;
    logic ov;
    logic cy;
    logic lt;  // Signed less than

    assign z  = psw_i[PSW_Z];
    assign s  = psw_i[PSW_S];
    assign ov = psw_i[PSW_OV];
    assign cy = psw_i[PSW_CY];
    assign lt = s ^ ov;

    always_comb begin
        cond_true_o = 1'b0;
        case (cond_i)
            COND_V:  cond_true_o = ov;
            COND_NV: cond_true_o = !ov;
            COND_C:  cond_true_o = cy;
            COND_NC: cond_true_o = !cy;
            COND_Z:  cond_true_o = z;
            COND_NZ: cond_true_o = !z;
            COND_NH: cond_true_o = cy | z;
            COND_H:  cond_true_o = !(cy | z);  // Both flags clear
            COND_N:  cond_true_o = s;
            COND_P:  cond_true_o = !s;
            COND_T:  cond_true_o = 1'b1;
            COND_SA: cond_true_o = 1'b0;       // Reserved in this stage
            COND_LT: cond_true_o = lt;
            COND_GE: cond_true_o = !lt;
            COND_LE: cond_true_o = lt | z;
            COND_GT: cond_true_o = !(lt | z);
            default: cond_true_o = 1'b0;
        endcase
    end

endmodule

// File: src/decode_stage.sv
module decode_stage
    import v850_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic [XLEN-1:0]   insn_i,
    input  logic [XLEN-1:0]   psw_i,
    input  logic              gpr_we_i,
    input  logic [REG_AW-1:0] gpr_waddr_i,
    input  logic [XLEN-1:0]   gpr_wdata_i,
    output op_kind_t          op_o,
    output logic [XLEN-1:0]   operand1_o,
    output logic [XLEN-1:0]   operand2_o,
    output logic [REG_AW-1:0] dest_o,
    output logic              dest_we_o,
    output logic              carry_in_o
);

    op_kind_t           op;
    logic [REG_AW-1:0]  reg1_num;
    logic [REG_AW-1:0]  reg2_num;
    logic [REG_AW-1:0]  reg3_num;
    logic [IMM5_W-1:0]  imm5;
    logic [IMM16_W-1:0] imm16;
    logic [COND_W-1:0]  cond;
    logic               src1_is_imm5;
    logic               src2_is_imm16;
    logic [XLEN-1:0]    rdata1;
    logic [XLEN-1:0]    rdata2;
    logic [XLEN-1:0]    sel_operand1;
    logic [XLEN-1:0]    sel_operand2;
    logic               cond_true;
    logic [REG_AW-1:0]  dest_d;
    logic               dest_we_d;
    logic               carry_d;

    insn_classifier u_classifier (
        .insn_i       (insn_i),
        .op_o         (op),
        .reg1_o       (reg1_num),
        .reg2_o       (reg2_num),
        .reg3_o       (reg3_num),
        .imm5_o       (imm5),
        .imm16_o      (imm16),
        .cond_o       (cond),
        .src1_imm5_o  (src1_is_imm5),
        .src2_imm16_o (src2_is_imm16)
    );

    gpr_file u_gpr (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (reg1_num),
        .raddr2_i (reg2_num),
        .we_i     (gpr_we_i),
        .waddr_i  (gpr_waddr_i),
        .wdata_i  (gpr_wdata_i),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_select u_opsel (
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .imm5_i       (imm5),
        .imm16_i      (imm16),
        .src1_imm5_i  (src1_is_imm5),
        .src2_imm16_i (src2_is_imm16),
        .operand1_o   (sel_operand1),
        .operand2_o   (sel_operand2)
    );

    cond_eval u_cond (
        .cond_i      (cond),
        .psw_i       (psw_i),
        .cond_true_o (cond_true)
    );

    // Destination, write enable and carry-in by operation
    always_comb begin
        dest_d    = '0;
        dest_we_d = 1'b0;
        carry_d   = 1'b0;
        case (op)
            OP_ADD, OP_SUB: begin
                dest_d    = reg2_num;
                dest_we_d = 1'b1;
            end
            OP_CMP: dest_d = reg2_num;  // Flags only, no register write
            OP_ADF, OP_SBF: begin
                dest_d    = reg3_num;   // Three-operand form
                dest_we_d = 1'b1;
                carry_d   = cond_true;
            end
            default: dest_d = '0;
        endcase
    end

    // Output stage, one cycle after the sampling edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            op_o       <= OP_NONE;
            operand1_o <= '0;
            operand2_o <= '0;
            dest_o     <= '0;
            dest_we_o  <= 1'b0;
            carry_in_o <= 1'b0;
        end else begin
            op_o       <= op;
            operand1_o <= (op == OP_NONE) ? '0 : sel_operand1;  // Zero for unknown words
            operand2_o <= (op == OP_NONE) ? '0 : sel_operand2;
            dest_o     <= dest_d;
            dest_we_o  <= dest_we_d;
            carry_in_o <= carry_d;
        end
    end

    // Writeback must never see a write for a compare or a dropped word
    a_no_we_on_none_cmp: assert property (
        @(posedge clk) disable iff (reset_i)
        ((op_o == OP_NONE) || (op_o == OP_CMP)) |-> !dest_we_o
    ) else $error("dest_we_o high with op_o %s", op_o.name());

endmodule

// File: test/tb_decode_stage.sv
module tb_decode_stage
    import v850_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              reset_i;
    logic [XLEN-1:0]   insn_i;
    logic [XLEN-1:0]   psw_i;
    logic              gpr_we_i;
    logic [REG_AW-1:0] gpr_waddr_i;
    logic [XLEN-1:0]   gpr_wdata_i;
    op_kind_t          op_o;
    logic [XLEN-1:0]   operand1_o;
    logic [XLEN-1:0]   operand2_o;
    logic [REG_AW-1:0] dest_o;
    logic              dest_we_o;
    logic              carry_in_o;

    logic [XLEN-1:0] gpr_model [NUM_REGS];  // Mirror of the register file
    integer          seed;
    int              error_count;

    decode_stage UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .insn_i      (insn_i),
        .psw_i       (psw_i),
        .gpr_we_i    (gpr_we_i),
        .gpr_waddr_i (gpr_waddr_i),
        .gpr_wdata_i (gpr_wdata_i),
        .op_o        (op_o),
        .operand1_o  (operand1_o),
        .operand2_o  (operand2_o),
        .dest_o      (dest_o),
        .dest_we_o   (dest_we_o),
        .carry_in_o  (carry_in_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Format I and II word, reg2 at 15:11
    function automatic logic [XLEN-1:0] fmt_reg(input logic [5:0] opc, input logic [4:0] r1,
                                                 input logic [4:0] r2);
        fmt_reg = {16'h0000, r2, opc, r1};
    endfunction

    // Format VI word, imm16 in the upper halfword
    function automatic logic [XLEN-1:0] fmt_imm16(input logic [5:0] opc, input logic [4:0] r1,
                                                   input logic [4:0] r2, input logic [15:0] imm);
        fmt_imm16 = {imm, r2, opc, r1};
    endfunction

    // Extended word: reg3, sub-opcode, cccc, bit 16, reg2, opcode, reg1
    function automatic logic [XLEN-1:0] fmt_ext(input logic [5:0] sub, input logic [3:0] cond,
                                                 input logic b16, input logic [4:0] r1,
                                                 input logic [4:0] r2, input logic [4:0] r3);
        fmt_ext = {r3, sub, cond, b16, r2, OPC_EXT, r1};
    endfunction

    // Low three bits pick the test, bit 3 inverts it (T and SA are a pair too)
    function automatic logic cond_holds(input logic [3:0] cond, input logic [XLEN-1:0] psw);
        logic base;
        base = 1'b0;
        case (cond[2:0])
            3'b000: base = psw[PSW_OV];
            3'b001: base = psw[PSW_CY];
            3'b010: base = psw[PSW_Z];
            3'b011: base = psw[PSW_CY] | psw[PSW_Z];
            3'b100: base = psw[PSW_S];
            3'b101: base = 1'b1;
            3'b110: base = psw[PSW_S] ^ psw[PSW_OV];
            3'b111: base = (psw[PSW_S] ^ psw[PSW_OV]) | psw[PSW_Z];
            default: base = 1'b0;
        endcase
        cond_holds = base ^ cond[3];
    endfunction

    task automatic compare(input string name, input logic [XLEN-1:0] expected,
                           input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h got %h at %0t", name, expected, actual, $time);
            error_count++;
        end
    endtask

    task automatic check_outputs(input op_kind_t exp_op, input logic [XLEN-1:0] exp_op1,
                                 input logic [XLEN-1:0] exp_op2, input logic [4:0] exp_dest,
                                 input logic exp_we, input logic exp_carry);
        compare("op_o", 32'(exp_op), 32'(op_o));
        compare("operand1_o", exp_op1, operand1_o);
        compare("operand2_o", exp_op2, operand2_o);
        compare("dest_o", 32'(exp_dest), 32'(dest_o));
        compare("dest_we_o", 32'(exp_we), 32'(dest_we_o));
        compare("carry_in_o", 32'(exp_carry), 32'(carry_in_o));
    endtask

    // Dropped word, dest not defined
    task automatic check_unsupported();
        compare("op_o", 32'(OP_NONE), 32'(op_o));
        compare("operand1_o", '0, operand1_o);
        compare("operand2_o", '0, operand2_o);
        compare("dest_we_o", 32'h0, 32'(dest_we_o));
        compare("carry_in_o", 32'h0, 32'(carry_in_o));
    endtask

    task automatic apply_insn(input logic [XLEN-1:0] word, input logic [XLEN-1:0] psw);
        @(posedge clk);
        insn_i <= word;
        psw_i  <= psw;
        @(posedge clk);  // Sampling edge
        @(negedge clk);  // Registered result settled
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
        @(posedge clk);
        gpr_we_i    <= 1'b1;
        gpr_waddr_i <= addr;
        gpr_wdata_i <= data;
        @(posedge clk);  // Write lands here
        gpr_we_i <= 1'b0;
        if (addr != 5'd0) begin
            gpr_model[addr] = data;  // r0 stays zero
        end
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while ((reset_i !== 1'b0) && (cycles < 20)) begin
            @(posedge clk);
            cycles++;
        end
        released = (reset_i === 1'b0);
    endtask

    // Outputs of the last reset edge, before any word is decoded
    task automatic test_reset_state();
        @(negedge clk);
        check_outputs(OP_NONE, '0, '0, 5'd0, 1'b0, 1'b0);
    endtask

    task automatic test_reg_reg();
        for (int i = 0; i < NUM_REGS; i++) begin
            write_reg(5'(i), $random(seed));  // r0 write must be dropped
        end
        for (int r1 = 0; r1 < NUM_REGS; r1++) begin
            for (int r2 = 0; r2 < NUM_REGS; r2++) begin
                apply_insn(fmt_reg(OPC_ADD_R, 5'(r1), 5'(r2)), '0);
                check_outputs(OP_ADD, gpr_model[r1], gpr_model[r2], 5'(r2), 1'b1, 1'b0);
                apply_insn(fmt_reg(OPC_SUB_R, 5'(r1), 5'(r2)), '0);
                check_outputs(OP_SUB, gpr_model[r1], gpr_model[r2], 5'(r2), 1'b1, 1'b0);
                apply_insn(fmt_reg(OPC_CMP_R, 5'(r1), 5'(r2)), '0);
                check_outputs(OP_CMP, gpr_model[r1], gpr_model[r2], 5'(r2), 1'b0, 1'b0);
            end
        end
    endtask

    task automatic test_immediates();
        logic [4:0]      imm5;
        logic [4:0]      r1;
        logic [4:0]      r2;
        logic [15:0]     imm16;
        logic [XLEN-1:0] sx;
        for (int v = 0; v < 32; v++) begin  // Every imm5, both signs
            imm5 = 5'(v);
            r2   = 5'($random(seed));
            sx   = {{27{imm5[4]}}, imm5};
            apply_insn(fmt_reg(OPC_ADD_I5, imm5, r2), '0);
            check_outputs(OP_ADD, sx, gpr_model[r2], r2, 1'b1, 1'b0);
            apply_insn(fmt_reg(OPC_CMP_I5, imm5, r2), '0);
            check_outputs(OP_CMP, sx, gpr_model[r2], r2, 1'b0, 1'b0);
        end
        for (int k = 0; k < 8; k++) begin
            case (k)
                0: imm16 = 16'h0000;
                1: imm16 = 16'h7fff;
                2: imm16 = 16'h8000;  // Most negative
                3: imm16 = 16'hffff;
                default: imm16 = 16'($random(seed));
            endcase
            r1 = 5'($random(seed));
            r2 = 5'($random(seed));
            apply_insn(fmt_imm16(OPC_ADDI, r1, r2, imm16), '0);
            check_outputs(OP_ADD, gpr_model[r1], {{16{imm16[15]}}, imm16}, r2, 1'b1, 1'b0);
        end
    endtask

    task automatic test_conditions();
        logic [XLEN-1:0] psw;
        logic [4:0]      r1;
        logic [4:0]      r2;
        logic [4:0]      r3;
        for (int c = 0; c < 16; c++) begin
            for (int k = 0; k < 4; k++) begin
                psw = $random(seed);
                r1  = 5'($random(seed));
                r2  = 5'($random(seed));
                r3  = 5'($random(seed));
                for (int s = 0; s < 2; s++) begin
                    apply_insn(fmt_ext(s ? SUB_SBF : SUB_ADF, 4'(c), 1'b0, r1, r2, r3), psw);
                    if (4'(c) == COND_SA) begin
                        check_unsupported();
                    end else begin
                        check_outputs(s ? OP_SBF : OP_ADF, gpr_model[r1], gpr_model[r2], r3,
                                      1'b1, cond_holds(4'(c), psw));
                    end
                end
            end
        end
    endtask

    task automatic test_unsupported();
        logic [XLEN-1:0] words [6];
        words[0] = 32'h0000_0000;                             // NOP
        words[1] = fmt_reg(6'b000000, 5'd3, 5'd4);            // MOV r3,r4
        words[2] = fmt_reg(6'b110001, 5'd1, 5'd2);            // MOVEA
        words[3] = fmt_ext(6'b000000, COND_T, 1'b0, 5'd1, 5'd2, 5'd3);
        words[4] = fmt_ext(SUB_ADF, COND_C, 1'b1, 5'd1, 5'd2, 5'd3);  // Bit 16 set
        words[5] = fmt_ext(SUB_SBF, COND_Z, 1'b1, 5'd4, 5'd5, 5'd6);
        for (int i = 0; i < 6; i++) begin
            apply_insn(words[i], $random(seed));
            check_unsupported();
        end
    endtask

    task automatic test_back_to_back();
        logic [XLEN-1:0] old_r5;
        logic [XLEN-1:0] new_r5;
        old_r5 = gpr_model[5];
        new_r5 = ~old_r5;  // Always differs
        @(posedge clk);
        insn_i      <= fmt_reg(OPC_ADD_R, 5'd5, 5'd6);
        psw_i       <= '0;
        gpr_we_i    <= 1'b1;
        gpr_waddr_i <= 5'd5;
        gpr_wdata_i <= new_r5;
        @(posedge clk);  // ADD sampled while r5 is written
        insn_i   <= fmt_reg(OPC_SUB_R, 5'd5, 5'd7);
        gpr_we_i <= 1'b0;
        gpr_model[5] = new_r5;
        @(negedge clk);
        check_outputs(OP_ADD, old_r5, gpr_model[6], 5'd6, 1'b1, 1'b0);
        @(posedge clk);  // SUB sampled, sees new r5
        insn_i <= fmt_reg(OPC_CMP_I5, 5'h1f, 5'd5);
        @(negedge clk);
        check_outputs(OP_SUB, new_r5, gpr_model[7], 5'd7, 1'b1, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_outputs(OP_CMP, 32'hffff_ffff, new_r5, 5'd5, 1'b0, 1'b0);
    endtask

    initial begin
        logic released;
        seed        = 20;
        error_count = 0;
        reset_i     <= 1'b1;
        // ADF with T would set every output if reset were ignored
        insn_i      <= fmt_ext(SUB_ADF, COND_T, 1'b0, 5'd1, 5'd2, 5'd3);
        psw_i       <= '0;
        gpr_we_i    <= 1'b0;
        gpr_waddr_i <= '0;
        gpr_wdata_i <= '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            gpr_model[i] = '0;  // Reset clears every register
        end
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        test_reset_state();
        wait_reset_release(released);
        if (!released) begin
            $display("Timeout waiting for reset to be released");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            test_reg_reg();
            test_immediates();
            test_conditions();
            test_unsupported();
            test_back_to_back();
            $display("Decode stage checks finished with %0d errors", error_count);
            if (error_count == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: verilog.f
src/v850_pkg.sv
src/gpr_file.sv
src/insn_classifier.sv
src/operand_select.sv
src/cond_eval.sv
src/decode_stage.sv
test/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -f verilog.f --top-module tb_decode_stage \
    -o tb_decode_stage \
    && ./obj_dir/tb_decode_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Simulation build or run failed"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
exit 0
